// ==== hdl/bpPkg.sv ====
//////////////////////////////////////////////////
// Branch predictor package
// Shared PC width, PC type and the 2-bit
// saturating counter encoding
//////////////////////////////////////////////////

package bpPkg;

  // Instruction address width
  localparam int Xlen = 32;

  // Instruction address
  typedef logic [Xlen-1:0] pcT;

  // Two-bit saturating counter
  // Top bit set means predict taken
  typedef enum logic [1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } counterT;

  // Counter value after reset and in a flushed stage
  localparam counterT CounterReset = weakNotTaken;

endpackage

// ==== hdl/phtSram.sv ====
//////////////////////////////////////////////////
// Pattern history table
// 2^HistoryBits saturating counters, one read port
// with registered output, one write port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module phtSram import bpPkg::*; #(
  parameter int HistoryBits = 10
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [HistoryBits-1:0] readAddr,
  input  logic                   readEn,
  output counterT                readData,
  input  logic [HistoryBits-1:0] writeAddr,
  input  counterT                writeData,
  input  logic                   writeEn
);

  localparam int Depth = 2 ** HistoryBits;

  counterT mem [Depth];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  // Every counter starts weakly not taken
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= CounterReset;
      end
    end else if (writeEn) begin
      mem[writeAddr] <= writeData;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Read before write on an address collision,
  // the old entry comes out
  // Output holds while readEn is low
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      readData <= CounterReset;
    end else if (readEn) begin
      readData <= mem[readAddr];
    end
  end

endmodule

// ==== hdl/localHistoryPredictor.sv ====
//////////////////////////////////////////////////
// Local history predictor
// Hashes the PC into a bank of per-branch history
// registers, the history then indexes the PHT
// Same-cycle updates are forwarded to the lookup
//////////////////////////////////////////////////

`timescale 1ns/1ps

module localHistoryPredictor import bpPkg::*; #(
  parameter int HistIndexBits = 6,
  parameter int HistoryBits   = 10
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   StallF,
  input  logic                   FlushF,
  input  pcT                     LookUpPC,
  input  pcT                     UpdatePC,
  input  logic                   UpdateEN,
  input  logic                   PCSrcE,
  input  counterT                UpdateCounter,
  input  logic [HistoryBits-1:0] HistoryE,
  output counterT                PredictionF,
  output logic [HistoryBits-1:0] HistoryF
);

  localparam int NumHist = 2 ** HistIndexBits;

  typedef logic [HistoryBits-1:0]   historyT;
  typedef logic [HistIndexBits-1:0] histIdxT;

  histIdxT lookUpIdx;
  histIdxT updateIdx;
  historyT histBank [NumHist];
  historyT updateHistory;
  historyT lookUpHistory;
  logic    histForward;
  logic    bypassHit;
  logic    bypassHitF;
  counterT bypassCounterF;
  counterT tableData;

  //////////////////////////////////////////////////
  // PC hashing
  //////////////////////////////////////////////////

  // Word-aligned PC bits, top index bit folded with PC[1]
  // so compressed halfword branches spread out
  assign lookUpIdx = {LookUpPC[HistIndexBits+1] ^ LookUpPC[1], LookUpPC[HistIndexBits:2]};
  assign updateIdx = {UpdatePC[HistIndexBits+1] ^ UpdatePC[1], UpdatePC[HistIndexBits:2]};

  //////////////////////////////////////////////////
  // Local history bank
  //////////////////////////////////////////////////

  // Newest outcome enters at the top, oldest drops out at bit 0
  assign updateHistory = {PCSrcE, histBank[updateIdx][HistoryBits-1:1]};

  for (genvar i = 0; i < NumHist; i++) begin : gHist
    // Only the register the resolving branch maps to shifts
    always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
        histBank[i] <= '0;
      end else if (UpdateEN && (updateIdx == histIdxT'(i))) begin
        histBank[i] <= updateHistory;
      end
    end
  end

  // Lookup sees the history that is being written this cycle
  assign histForward   = UpdateEN && (lookUpIdx == updateIdx);
  assign lookUpHistory = histForward ? updateHistory : histBank[lookUpIdx];

  //////////////////////////////////////////////////
  // Pattern history table
  //////////////////////////////////////////////////

  // Counter update goes to the entry execute predicted from
  phtSram #(
    .HistoryBits(HistoryBits)
  ) i_pht (
    .clk      (clk),
    .rstN     (rstN),
    .readAddr (lookUpHistory),
    .readEn   (~StallF),
    .readData (tableData),
    .writeAddr(HistoryE),
    .writeData(UpdateCounter),
    .writeEn  (UpdateEN)
  );

  // Table returns the stale counter on a read/write collision
  assign bypassHit = UpdateEN && (HistoryE == lookUpHistory);

  // Captured alongside the table read so both hold under StallF
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bypassHitF <= 1'b0;
    end else if (!StallF) begin
      bypassHitF <= bypassHit;
    end
  end

  always_ff @(posedge clk) begin
    if (!StallF) begin
      bypassCounterF <= UpdateCounter;
    end
  end

  assign PredictionF = bypassHitF ? bypassCounterF : tableData;

  //////////////////////////////////////////////////
  // Fetch history register
  //////////////////////////////////////////////////

  // History the prediction came from, carried down to execute
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      HistoryF <= '0;
    end else if (FlushF) begin
      HistoryF <= '0;
    end else if (!StallF) begin
      HistoryF <= lookUpHistory;
    end
  end

endmodule

// ==== hdl/predictionPipe.sv ====
//////////////////////////////////////////////////
// Prediction pipe
// Decode and execute registers carrying each
// prediction and its history down to resolution
//////////////////////////////////////////////////

`timescale 1ns/1ps

module predictionPipe import bpPkg::*; #(
  parameter int HistoryBits = 10
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   StallD,
  input  logic                   StallE,
  input  logic                   FlushD,
  input  logic                   FlushE,
  input  counterT                PredictionF,
  input  logic [HistoryBits-1:0] HistoryF,
  output counterT                PredictionD,
  output logic [HistoryBits-1:0] HistoryD,
  output counterT                PredictionE,
  output logic [HistoryBits-1:0] HistoryE
);

  //////////////////////////////////////////////////
  // Decode stage
  //////////////////////////////////////////////////

  // Flush wins over stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      PredictionD <= CounterReset;
      HistoryD    <= '0;
    end else if (FlushD) begin
      PredictionD <= CounterReset;
      HistoryD    <= '0;
    end else if (!StallD) begin
      PredictionD <= PredictionF;
      HistoryD    <= HistoryF;
    end
  end

  //////////////////////////////////////////////////
  // Execute stage
  //////////////////////////////////////////////////

  // Bubble looks like an untrained entry 0
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      PredictionE <= CounterReset;
      HistoryE    <= '0;
    end else if (FlushE) begin
      PredictionE <= CounterReset;
      HistoryE    <= '0;
    end else if (!StallE) begin
      PredictionE <= PredictionD;
      HistoryE    <= HistoryD;
    end
  end

endmodule

// ==== hdl/branchResolve.sv ====
//////////////////////////////////////////////////
// Branch resolve
// Steps the saturating counter toward the real
// outcome and flags a direction mispredict
//////////////////////////////////////////////////

`timescale 1ns/1ps

module branchResolve import bpPkg::*; (
  input  logic    BranchE,
  input  logic    PCSrcE,
  input  logic    StallE,
  input  counterT PredictionE,
  output logic    UpdateEN,
  output counterT UpdateCounter,
  output logic    MispredictE
);

  // A stalled branch resolves again next cycle, so write only once
  assign UpdateEN = BranchE && !StallE;

  // Saturating step, held at the two strong ends
  always_comb begin
    case (PredictionE)
      strongNotTaken: UpdateCounter = PCSrcE ? weakNotTaken : strongNotTaken;
      weakNotTaken:   UpdateCounter = PCSrcE ? weakTaken    : strongNotTaken;
      weakTaken:      UpdateCounter = PCSrcE ? strongTaken  : weakNotTaken;
      strongTaken:    UpdateCounter = PCSrcE ? strongTaken  : weakTaken;
      default:        UpdateCounter = CounterReset;
    endcase
  end

  // Predicted direction is the counter's top bit
  assign MispredictE = BranchE && (PredictionE[1] != PCSrcE);

endmodule

// ==== hdl/branchPredictor.sv ====
//////////////////////////////////////////////////
// Branch direction predictor top
// Local history lookup in fetch, prediction pipe
// through decode, resolution and update in execute
//////////////////////////////////////////////////

`timescale 1ns/1ps

module branchPredictor import bpPkg::*; #(
  parameter int HistIndexBits = 6,
  parameter int HistoryBits   = 10
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    StallF,
  input  logic    StallD,
  input  logic    StallE,
  input  logic    FlushF,
  input  logic    FlushD,
  input  logic    FlushE,
  input  pcT      LookUpPC,
  input  pcT      PCE,
  input  logic    BranchE,
  input  logic    PCSrcE,
  output counterT PredictionF,
  output counterT PredictionE,
  output logic    MispredictE
);

  logic [HistoryBits-1:0] historyF;
  logic [HistoryBits-1:0] historyE;
  logic                   updateEn;
  counterT                updateCounter;

  // Fetch lookup and execute update
  localHistoryPredictor #(
    .HistIndexBits(HistIndexBits),
    .HistoryBits  (HistoryBits)
  ) i_predictor (
    .clk          (clk),
    .rstN         (rstN),
    .StallF       (StallF),
    .FlushF       (FlushF),
    .LookUpPC     (LookUpPC),
    .UpdatePC     (PCE),
    .UpdateEN     (updateEn),
    .PCSrcE       (PCSrcE),
    .UpdateCounter(updateCounter),
    .HistoryE     (historyE),
    .PredictionF  (PredictionF),
    .HistoryF     (historyF)
  );

  // Decode-stage copies are not needed at this level
  predictionPipe #(
    .HistoryBits(HistoryBits)
  ) i_pipe (
    .clk        (clk),
    .rstN       (rstN),
    .StallD     (StallD),
    .StallE     (StallE),
    .FlushD     (FlushD),
    .FlushE     (FlushE),
    .PredictionF(PredictionF),
    .HistoryF   (historyF),
    .PredictionD(),
    .HistoryD   (),
    .PredictionE(PredictionE),
    .HistoryE   (historyE)
  );

  branchResolve i_resolve (
    .BranchE      (BranchE),
    .PCSrcE       (PCSrcE),
    .StallE       (StallE),
    .PredictionE  (PredictionE),
    .UpdateEN     (updateEn),
    .UpdateCounter(updateCounter),
    .MispredictE  (MispredictE)
  );

endmodule

// ==== sim/branchPredictorTb.sv ====
//////////////////////////////////////////////////
// Branch predictor testbench
// Directed tests checked against a local history
// reference model of histories and counters
//////////////////////////////////////////////////

`timescale 1ns/1ps

module branchPredictorTb import bpPkg::*; ();

  localparam int HistIndexBits = 4;
  localparam int HistoryBits   = 4;
  localparam int MaxCycles     = 4000;
  localparam int unsigned Seed = 32'hb70f_255c;

  logic    clk, rstN, StallF, StallD, StallE, FlushF, FlushD, FlushE;
  logic    BranchE, PCSrcE, MispredictE;
  pcT      LookUpPC, PCE;
  counterT PredictionF, PredictionE;

  // Reference model state
  logic [HistoryBits-1:0] mHist [2**HistIndexBits];
  counterT                mCnt [2**HistoryBits];

  int          errCount, testPass, testFail, cycles;
  int unsigned seedDummy;
  counterT     lastPredE;
  logic        lastMis;
  pcT          pcPool [8];

  branchPredictor #(
    .HistIndexBits(HistIndexBits),
    .HistoryBits  (HistoryBits)
  ) i_dut (
    .clk(clk), .rstN(rstN),
    .StallF(StallF), .StallD(StallD), .StallE(StallE),
    .FlushF(FlushF), .FlushD(FlushD), .FlushE(FlushE),
    .LookUpPC(LookUpPC), .PCE(PCE), .BranchE(BranchE), .PCSrcE(PCSrcE),
    .PredictionF(PredictionF), .PredictionE(PredictionE), .MispredictE(MispredictE)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Hard stop on a hung run
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Word bits of the PC, top index bit folded with PC[1]
  function automatic logic [HistIndexBits-1:0] idxOf(pcT pc);
    return {pc[HistIndexBits+1] ^ pc[1], pc[HistIndexBits:2]};
  endfunction

  // One step toward the outcome, stuck at either end
  function automatic counterT stepModel(counterT c, logic taken);
    logic [1:0] v;
    v = c;
    if (taken && v != 2'b11) v = v + 2'b01;
    else if (!taken && v != 2'b00) v = v - 2'b01;
    return counterT'(v);
  endfunction

  function automatic counterT modelPredict(pcT pc);
    return mCnt[mHist[idxOf(pc)]];
  endfunction

  task automatic modelUpdate(pcT pc, logic taken);
    logic [HistoryBits-1:0] old;
    old = mHist[idxOf(pc)];
    mCnt[old] = stepModel(mCnt[old], taken);
    mHist[idxOf(pc)] = {taken, old[HistoryBits-1:1]};
  endtask

  //////////////////////////////////////////////////
  // Checks and reporting
  //////////////////////////////////////////////////

  task automatic checkCounter(string name, counterT got, counterT exp);
    if (got !== exp) begin
      errCount++;
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      errCount++;
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic reportTest(string name, int errBefore);
    if (errCount == errBefore) begin
      testPass++;
      $display("PASS %s", name);
    end else begin
      testFail++;
      $display("FAIL %s (%0d errors)", name, errCount - errBefore);
    end
  endtask

  // Lookup, carry to execute, resolve, then check the same-cycle relookup
  task automatic lookupResolve(pcT pc, logic taken);
    counterT expF;
    @(posedge clk);
    LookUpPC <= pc;
    expF = modelPredict(pc);
    @(posedge clk);
    @(negedge clk);
    checkCounter("PredictionF", PredictionF, expF);
    repeat (2) @(posedge clk);
    BranchE <= 1'b1;
    PCE     <= pc;
    PCSrcE  <= taken;
    @(negedge clk);
    checkCounter("PredictionE", PredictionE, expF);
    checkBit("MispredictE", MispredictE, expF[1] != taken);
    lastPredE = PredictionE;
    lastMis   = MispredictE;
    // Update written here while the same PC is looked up
    @(posedge clk);
    BranchE <= 1'b0;
    modelUpdate(pc, taken);
    @(negedge clk);
    checkCounter("PredictionF forwarded", PredictionF, modelPredict(pc));
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic testReset();
    int errBefore;
    errBefore = errCount;
    repeat (4) begin
      @(posedge clk);
      LookUpPC <= $urandom;
      @(posedge clk);
      @(negedge clk);
      checkCounter("PredictionF", PredictionF, modelPredict(LookUpPC));
      checkBit("MispredictE", MispredictE, 1'b0);
    end
    reportTest("reset state", errBefore);
  endtask

  task automatic testTraining();
    int errBefore;
    errBefore = errCount;
    repeat (12) lookupResolve(32'h0000_1000, 1'b1);
    checkCounter("PredictionE saturated", lastPredE, strongTaken);
    reportTest("training one branch", errBefore);
  endtask

  task automatic testPattern();
    int errBefore;
    errBefore = errCount;
    for (int i = 0; i < 30; i++) begin
      lookupResolve(32'h0000_1004, !i[0]);
      // Both pattern entries are trained well before this point
      if (i >= 20) checkBit("MispredictE trained", lastMis, 1'b0);
    end
    reportTest("local pattern", errBefore);
  endtask

  // Not taken on zero history hits the bypass, taken shifts the history
  task automatic testForwarding();
    int errBefore;
    errBefore = errCount;
    for (int i = 0; i < 8; i++) lookupResolve(32'h0000_2008, i >= 3);
    reportTest("forwarding", errBefore);
  endtask

  task automatic testStallFlush();
    int      errBefore;
    counterT expF;
    errBefore = errCount;
    @(posedge clk);
    LookUpPC <= 32'h0000_1000;
    expF = modelPredict(32'h0000_1000);
    // Next PC sits on another history register with a different counter
    @(posedge clk);
    LookUpPC <= 32'h0000_300c;
    StallF   <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      checkCounter("PredictionF stalled", PredictionF, expF);
      @(posedge clk);
    end
    // Bubble into execute while decode keeps the stalled prediction
    StallF <= 1'b0;
    FlushE <= 1'b1;
    @(posedge clk);
    FlushE  <= 1'b0;
    StallD  <= 1'b1;
    StallE  <= 1'b1;
    BranchE <= 1'b1;
    PCE     <= 32'h0000_1000;
    PCSrcE  <= 1'b0;
    @(negedge clk);
    checkCounter("PredictionE flushed", PredictionE, CounterReset);
    // Branch held in a stalled execute must not train
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      checkCounter("PredictionE stalled", PredictionE, CounterReset);
    end
    @(posedge clk);
    StallD  <= 1'b0;
    StallE  <= 1'b0;
    BranchE <= 1'b0;
    // Decode hands on the prediction it held
    @(posedge clk);
    @(negedge clk);
    checkCounter("PredictionE released", PredictionE, expF);
    // Model was not updated, so any stray write shows up here
    lookupResolve(32'h0000_1000, 1'b1);
    reportTest("stall and flush", errBefore);
  endtask

  task automatic testRandom();
    int          errBefore;
    logic [31:0] r;
    errBefore = errCount;
    for (int i = 0; i < 8; i++) pcPool[i] = $urandom;
    repeat (200) begin
      r = $urandom;
      lookupResolve(pcPool[r[2:0]], r[8]);
    end
    reportTest("random mix", errBefore);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    seedDummy = $urandom(Seed);
    rstN = 1'b0;
    {StallF, StallD, StallE, FlushF, FlushD, FlushE} = '0;
    BranchE  = 1'b0;
    PCSrcE   = 1'b0;
    LookUpPC = '0;
    PCE      = '0;
    mHist = '{default: '0};
    mCnt  = '{default: CounterReset};
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    testReset();
    testTraining();
    testPattern();
    testForwarding();
    testStallFlush();
    testRandom();
    $display("Tests passed %0d, failed %0d, check errors %0d", testPass, testFail, errCount);
    if (errCount == 0 && testFail == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hdl/bpPkg.sv
hdl/phtSram.sv
hdl/localHistoryPredictor.sv
hdl/predictionPipe.sv
hdl/branchResolve.sv
hdl/branchPredictor.sv
sim/branchPredictorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module branchPredictorTb -f all.f -o simBp

output=$(./obj_dir/simBp)
echo "$output"
grep -qx "TEST OK" <<< "$output"
